// File: project.f
+incdir+include
verilog/afe_pkg.sv
verilog/afe_cfg_regs.sv
verilog/adc_capture.sv
verilog/linear_calib.sv
verilog/dac_encode.sv
verilog/afe_top.sv
verification/tb_afe.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile the front end testbench with Verilator and run it
# the run passes only when the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
  --top-module tb_afe --Mdir obj_dir \
  -f project.f \
  || { echo "verilator build failed"; exit 1; }

sim_out="$(./obj_dir/Vtb_afe 2>&1)"
echo "${sim_out}"

# exact line match on the pass line
echo "${sim_out}" | grep -qx "test passed" \
  && { echo "simulation ok"; exit 0; } \
  || { echo "simulation not ok"; exit 1; }

// File: include/tb_afe_model.svh
/*
 * reference model of the front end datapath and register mirror
 * typed compare tasks for samples, codes and bus words
 */

`ifndef TB_AFE_MODEL_SVH
`define TB_AFE_MODEL_SVH

////////////////////////////////////////
// datapath model
////////////////////////////////////////

// inverted offset code, top bit kept, lower bits inverted
function automatic sample_t adc_word_to_smp(input logic [adc_raw_w-1:0] raw);
  logic [smp_w-1:0] top;
  top = raw[adc_raw_w-1 -: smp_w];
  return sample_t'(top ^ {1'b0, {(smp_w-1){1'b1}}});
endfunction

function automatic logic [smp_w-1:0] smp_to_code(input sample_t smp);
  return smp ^ {1'b0, {(smp_w-1){1'b1}}};
endfunction

// gain in 2.14 fixed point, then offset, then clamp to the sample range
function automatic sample_t calib_model(input sample_t smp, input gain_t gain,
                                        input offset_t offset);
  longint acc;
  longint lim;
  lim = longint'(1) <<< (smp_w - 1);
  acc = longint'(smp) * longint'(gain);
  // floor of the division by 2^14
  acc = acc >>> gain_shift;
  acc = acc + longint'(offset);
  if (acc >= lim) begin
    acc = lim - 1;
  end else if (acc < -lim) begin
    acc = -lim;
  end
  return sample_t'(acc);
endfunction

////////////////////////////////////////
// register mirror
////////////////////////////////////////

function automatic void model_write(input logic [wb_adr_w-1:0] adr, input cfg_word_u w);
  int ch;
  ch = int'(adr) - int'(reg_adc_cal0);
  if (adr == reg_ctrl) begin
    loop_m = w.ctrl.loop_en;
  end else if (adr == reg_adc_cal0 || adr == reg_adc_cal1) begin
    adc_gain_m[ch] = w.cal.gain;
    adc_off_m[ch] = w.cal.offset;
  end else if (adr == reg_dac_cal0 || adr == reg_dac_cal1) begin
    // dac registers follow the two adc ones
    dac_gain_m[ch-2] = w.cal.gain;
    dac_off_m[ch-2] = w.cal.offset;
  end
endfunction

// read value with unused bits 0, unmapped addresses 0
function automatic cfg_word_u expected_word(input logic [wb_adr_w-1:0] adr);
  cfg_word_u w;
  int ch;
  w = '0;
  ch = int'(adr) - int'(reg_adc_cal0);
  if (adr == reg_ctrl) begin
    w.ctrl.loop_en = loop_m;
  end else if (adr == reg_adc_cal0 || adr == reg_adc_cal1) begin
    w.cal.gain = adc_gain_m[ch];
    w.cal.offset = adc_off_m[ch];
  end else if (adr == reg_dac_cal0 || adr == reg_dac_cal1) begin
    w.cal.gain = dac_gain_m[ch-2];
    w.cal.offset = dac_off_m[ch-2];
  end
  return w;
endfunction

////////////////////////////////////////
// compare tasks
////////////////////////////////////////

task automatic check_sample(input int ch, input sample_t got, input sample_t exp);
  if (got !== exp) begin
    value_errs++;
    $display("[FAIL] %0t ns adc_smp_o[%0d] is %0d, expected %0d", $time, ch, got, exp);
  end
endtask

task automatic check_code(input int ch, input logic [smp_w-1:0] got,
                          input logic [smp_w-1:0] exp);
  if (got !== exp) begin
    value_errs++;
    $display("[FAIL] %0t ns dac_code_o[%0d] is %h, expected %h", $time, ch, got, exp);
  end
endtask

task automatic check_word(input logic [wb_adr_w-1:0] adr, input cfg_word_u got,
                          input cfg_word_u exp);
  if (got !== exp) begin
    value_errs++;
    $display("[FAIL] %0t ns read of address %0d is %h, expected %h", $time, adr, got, exp);
  end
endtask

`endif

// File: verification/tb_afe.sv
/*
 * testbench of the two-channel front end
 * clock, reset, Wishbone tasks, random streams, scoreboard and summary
 */

`timescale 1ns/1ns

module tb_afe;

  import afe_pkg::*;

  logic adc_clk = 1'b0;
  logic top_rst;
  logic [chan_num-1:0][adc_raw_w-1:0] adc_dat_i;
  sample_t [chan_num-1:0] dac_smp_i;
  logic [chan_num-1:0] dac_vld_i;
  sample_t [chan_num-1:0] adc_smp_o;
  logic [chan_num-1:0] adc_vld_o;
  logic [chan_num-1:0][smp_w-1:0] dac_code_o;
  logic wb_cyc_i;
  logic wb_stb_i;
  logic wb_we_i;
  logic [wb_adr_w-1:0] wb_adr_i;
  logic [wb_dat_w-1:0] wb_dat_i;
  logic [wb_dat_w-1:0] wb_dat_o;
  logic wb_ack_o;

  // mirror of the register bank
  logic loop_m;
  gain_t adc_gain_m [chan_num];
  gain_t dac_gain_m [chan_num];
  offset_t adc_off_m [chan_num];
  offset_t dac_off_m [chan_num];

  // scoreboard of expected values in output order
  sample_t adc_q [chan_num][$];
  logic [smp_w-1:0] dac_q [chan_num][$];
  logic [smp_w-1:0] cur_code [chan_num];
  // input valids delayed by the path latency
  logic [4:0] adc_mark [chan_num];
  logic [2:0] dac_mark [chan_num];
  logic [chan_num-1:0] adc_mark_in;
  logic check_adc;
  int seed;
  int value_errs;
  int valid_errs;
  cfg_word_u rd_word;

  `include "tb_afe_model.svh"

  afe_top u_afe_top (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .adc_dat_i  (adc_dat_i),
    .dac_smp_i  (dac_smp_i),
    .dac_vld_i  (dac_vld_i),
    .adc_smp_o  (adc_smp_o),
    .adc_vld_o  (adc_vld_o),
    .dac_code_o (dac_code_o),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o)
  );

  // 4 ns clock
  always #2 adc_clk = ~adc_clk;

  // adc tap 3 cycles behind the converter input and 5 in loopback
  always @(posedge adc_clk) begin
    for (int ch = 0; ch < chan_num; ch++) begin
      if (top_rst) begin
        adc_mark[ch] <= '0;
        dac_mark[ch] <= '0;
      end else begin
        adc_mark[ch] <= {adc_mark[ch][3:0], adc_mark_in[ch]};
        dac_mark[ch] <= {dac_mark[ch][1:0], dac_vld_i[ch]};
      end
    end
  end

  ////////////////////////////////////////
  // output monitor sampled mid cycle
  ////////////////////////////////////////

  always @(negedge adc_clk) begin : monitor
    logic tap;
    if (!top_rst) begin
      for (int ch = 0; ch < chan_num; ch++) begin
        if (dac_mark[ch][2] && dac_q[ch].size() != 0) begin
          cur_code[ch] = dac_q[ch].pop_front();
        end
        // code must hold between updates
        check_code(ch, dac_code_o[ch], cur_code[ch]);
        tap = loop_m ? adc_mark[ch][4] : adc_mark[ch][2];
        if (check_adc && tap) begin
          if (adc_vld_o[ch] !== 1'b1) begin
            valid_errs++;
            $display("%0t ns: adc channel %0d gave no valid sample when one was due", $time, ch);
          end else if (adc_q[ch].size() == 0) begin
            valid_errs++;
            $display("%0t ns: adc channel %0d has no expected sample left", $time, ch);
          end else begin
            check_sample(ch, adc_smp_o[ch], adc_q[ch].pop_front());
          end
        end else if (check_adc && loop_m && adc_vld_o[ch] !== 1'b0) begin
          valid_errs++;
          $display("%0t ns: adc channel %0d valid without a dac sample", $time, ch);
        end
      end
    end
  end

  ////////////////////////////////////////
  // bus and stream tasks
  ////////////////////////////////////////

  task automatic stop_on_timeout(input string what);
    $display("timeout: %s", what);
    $display("errors: %0d value, %0d valid", value_errs, valid_errs);
    $display("test failed");
    $finish;
  endtask

  task automatic wait_ack();
    int cycles;
    cycles = 0;
    @(negedge adc_clk);
    while (wb_ack_o !== 1'b1) begin
      cycles++;
      if (cycles > 16) begin
        stop_on_timeout("no Wishbone ack from the register bank");
      end
      @(negedge adc_clk);
    end
  endtask

  // request held until ack and written at the end of the ack cycle
  task automatic wb_write(input logic [wb_adr_w-1:0] adr, input cfg_word_u data);
    @(posedge adc_clk);
    #1;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i = 1'b1;
    wb_adr_i = adr;
    wb_dat_i = data;
    wait_ack();
    @(posedge adc_clk);
    #1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i = 1'b0;
    model_write(adr, data);
  endtask

  task automatic wb_read(input logic [wb_adr_w-1:0] adr, output cfg_word_u data);
    @(posedge adc_clk);
    #1;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_adr_i = adr;
    wait_ack();
    data = wb_dat_o;
    @(posedge adc_clk);
    #1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
  endtask

  task automatic read_and_check(input logic [wb_adr_w-1:0] adr);
    wb_read(adr, rd_word);
    check_word(adr, rd_word, expected_word(adr));
  endtask

  // random filler in the unused bits
  task automatic write_cal(input logic [wb_adr_w-1:0] adr, input gain_t gain,
                           input offset_t offset);
    cfg_word_u w;
    w = $random(seed);
    w.cal.gain = gain;
    w.cal.offset = offset;
    wb_write(adr, w);
  endtask

  task automatic run_stream(input int cycles, input logic adc_on, input logic dac_on);
    logic [adc_raw_w-1:0] raw;
    sample_t smp;
    sample_t cal;
    logic vld;
    repeat (cycles) begin
      @(posedge adc_clk);
      #1;
      for (int ch = 0; ch < chan_num; ch++) begin
        adc_mark_in[ch] = 1'b0;
        if (adc_on) begin
          raw = adc_raw_w'($random(seed));
          adc_dat_i[ch] = raw;
          smp = adc_word_to_smp(raw);
          adc_q[ch].push_back(calib_model(smp, adc_gain_m[ch], adc_off_m[ch]));
          adc_mark_in[ch] = 1'b1;
        end
        if (dac_on) begin
          // about one gap in four
          vld = ($random(seed) & 3) != 0;
          smp = sample_t'($random(seed));
          dac_smp_i[ch] = smp;
          dac_vld_i[ch] = vld;
          cal = calib_model(smp, dac_gain_m[ch], dac_off_m[ch]);
          if (vld) begin
            dac_q[ch].push_back(smp_to_code(cal));
          end
          if (vld && loop_m) begin
            adc_q[ch].push_back(calib_model(cal, adc_gain_m[ch], adc_off_m[ch]));
            adc_mark_in[ch] = 1'b1;
          end
        end
      end
    end
    @(posedge adc_clk);
    #1;
    dac_vld_i = '0;
    adc_mark_in = '0;
  endtask

  task automatic drain();
    int cycles;
    cycles = 0;
    while (adc_q[0].size() + adc_q[1].size() + dac_q[0].size() + dac_q[1].size() != 0) begin
      @(posedge adc_clk);
      cycles++;
      if (cycles > 32) begin
        stop_on_timeout("expected samples never came out of the DUT");
      end
    end
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    seed = 82471;
    top_rst = 1'b1;
    adc_dat_i = '0;
    dac_smp_i = '0;
    dac_vld_i = '0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    adc_mark_in = '0;
    check_adc = 1'b0;
    value_errs = 0;
    valid_errs = 0;
    loop_m = 1'b0;
    for (int ch = 0; ch < chan_num; ch++) begin
      adc_gain_m[ch] = gain_unity;
      dac_gain_m[ch] = gain_unity;
      adc_off_m[ch] = '0;
      dac_off_m[ch] = '0;
      cur_code[ch] = smp_to_code('0);
    end
    repeat (5) @(posedge adc_clk);
    #1;
    top_rst = 1'b0;

    // reset values and the unmapped address
    for (int a = 0; a <= 4; a++) read_and_check(a[wb_adr_w-1:0]);
    read_and_check(3'd7);
    wb_write(3'd7, $random(seed));
    for (int a = 0; a <= 4; a++) read_and_check(a[wb_adr_w-1:0]);

    // random words through both union views
    for (int a = 0; a <= 4; a++) wb_write(a[wb_adr_w-1:0], $random(seed));
    for (int a = 0; a <= 4; a++) read_and_check(a[wb_adr_w-1:0]);
    wb_write(reg_ctrl, '0);

    // converter path with saturating gains in the first two rounds
    check_adc = 1'b1;
    for (int r = 0; r < 6; r++) begin
      for (int ch = 0; ch < chan_num; ch++) begin
        write_cal(reg_adc_cal0 + ch[wb_adr_w-1:0],
                  (r == 0) ? 16'sh7fff : (r == 1) ? 16'sh8000 : gain_t'($random(seed)),
                  offset_t'($random(seed)));
      end
      run_stream(40, 1'b1, 1'b0);
      drain();
    end

    // dac path with gaps
    for (int r = 0; r < 4; r++) begin
      for (int ch = 0; ch < chan_num; ch++) begin
        write_cal(reg_dac_cal0 + ch[wb_adr_w-1:0], gain_t'($random(seed)),
                  offset_t'($random(seed)));
      end
      run_stream(60, 1'b0, 1'b1);
      drain();
    end

    // loopback after a flush of the converter samples
    check_adc = 1'b0;
    wb_write(reg_ctrl, 32'd1);
    for (int ch = 0; ch < chan_num; ch++) begin
      write_cal(reg_adc_cal0 + ch[wb_adr_w-1:0], gain_t'($random(seed)),
                offset_t'($random(seed)));
    end
    repeat (8) @(posedge adc_clk);
    #1;
    check_adc = 1'b1;
    run_stream(80, 1'b0, 1'b1);
    drain();
    repeat (4) @(posedge adc_clk);

    $display("errors: %0d value, %0d valid", value_errs, valid_errs);
    if (value_errs == 0 && valid_errs == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: verilog/adc_capture.sv
/*
 * ADC channel input register
 * offset code to two's complement, digital loopback mux
 */

`timescale 1ns/1ns

module adc_capture (
  input  logic                           adc_clk,
  input  logic                           top_rst,
  // raw converter word, low 2 bits unused
  input  logic [afe_pkg::adc_raw_w-1:0]  raw_i,
  // loopback from DAC calibration
  input  logic                           loop_en_i,
  input  afe_pkg::sample_t               loop_smp_i,
  input  logic                           loop_vld_i,
  // captured stream
  output afe_pkg::sample_t               smp_o,
  output logic                           vld_o
);

  import afe_pkg::*;

  // top 14 bits of the converter word
  logic [smp_w-1:0] raw_top;
  // converted sample
  sample_t adc_smp;
  sample_t smp_q;
  logic vld_q;

  assign raw_top = raw_i[adc_raw_w-1 -: smp_w];
  assign adc_smp = code_flip(raw_top);

  // sample register
  // loopback replaces the converter sample
  always_ff @(posedge adc_clk) begin
    smp_q <= loop_en_i ? loop_smp_i : adc_smp;
  end

  // converter runs continuously
  // in loopback the valid comes from the DAC path
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= loop_en_i ? loop_vld_i : 1'b1;
    end
  end

  assign smp_o = smp_q;
  assign vld_o = vld_q;

endmodule

// File: verilog/afe_cfg_regs.sv
/*
 * Wishbone classic register bank
 * loopback switch, ADC and DAC gain/offset pairs
 */

`timescale 1ns/1ns

module afe_cfg_regs (
  input  logic                                        adc_clk,
  input  logic                                        top_rst,
  // Wishbone slave
  input  logic                                        wb_cyc_i,
  input  logic                                        wb_stb_i,
  input  logic                                        wb_we_i,
  input  logic [afe_pkg::wb_adr_w-1:0]                wb_adr_i,
  input  afe_pkg::cfg_word_u                          wb_dat_i,
  output afe_pkg::cfg_word_u                          wb_dat_o,
  output logic                                        wb_ack_o,
  // configuration outputs
  output logic                                        loop_en_o,
  output afe_pkg::gain_t   [afe_pkg::chan_num-1:0]    adc_gain_o,
  output afe_pkg::gain_t   [afe_pkg::chan_num-1:0]    dac_gain_o,
  output afe_pkg::offset_t [afe_pkg::chan_num-1:0]    adc_offset_o,
  output afe_pkg::offset_t [afe_pkg::chan_num-1:0]    dac_offset_o
);

  import afe_pkg::*;

  logic req;
  logic ack_q;
  // request already acked, wait for stb to drop
  logic done_q;

  ////////////////////////////////////////
  // classic handshake
  ////////////////////////////////////////

  assign req = wb_cyc_i & wb_stb_i;

  // one ack per request, one cycle after it shows up
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      ack_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      ack_q <= req & ~ack_q & ~done_q;
      done_q <= req & (done_q | ack_q);
    end
  end

  assign wb_ack_o = ack_q;

  ////////////////////////////////////////
  // register writes
  ////////////////////////////////////////

  // write lands at the end of the ack cycle
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      loop_en_o <= 1'b0;
      adc_gain_o <= {chan_num{gain_unity}};
      dac_gain_o <= {chan_num{gain_unity}};
      adc_offset_o <= '0;
      dac_offset_o <= '0;
    end else if (ack_q && wb_we_i) begin
      case (wb_adr_i)
        reg_ctrl: loop_en_o <= wb_dat_i.ctrl.loop_en;
        reg_adc_cal0: begin
          adc_gain_o[0] <= wb_dat_i.cal.gain;
          adc_offset_o[0] <= wb_dat_i.cal.offset;
        end
        reg_adc_cal1: begin
          adc_gain_o[1] <= wb_dat_i.cal.gain;
          adc_offset_o[1] <= wb_dat_i.cal.offset;
        end
        reg_dac_cal0: begin
          dac_gain_o[0] <= wb_dat_i.cal.gain;
          dac_offset_o[0] <= wb_dat_i.cal.offset;
        end
        reg_dac_cal1: begin
          dac_gain_o[1] <= wb_dat_i.cal.gain;
          dac_offset_o[1] <= wb_dat_i.cal.offset;
        end
        // unmapped, ignored
        default: ;
      endcase
    end
  end

  // read mux, unused bits and unmapped addresses read 0
  always_comb begin
    wb_dat_o = '0;
    case (wb_adr_i)
      reg_ctrl: wb_dat_o.ctrl.loop_en = loop_en_o;
      reg_adc_cal0: begin
        wb_dat_o.cal.gain = adc_gain_o[0];
        wb_dat_o.cal.offset = adc_offset_o[0];
      end
      reg_adc_cal1: begin
        wb_dat_o.cal.gain = adc_gain_o[1];
        wb_dat_o.cal.offset = adc_offset_o[1];
      end
      reg_dac_cal0: begin
        wb_dat_o.cal.gain = dac_gain_o[0];
        wb_dat_o.cal.offset = dac_offset_o[0];
      end
      reg_dac_cal1: begin
        wb_dat_o.cal.gain = dac_gain_o[1];
        wb_dat_o.cal.offset = dac_offset_o[1];
      end
      default: ;
    endcase
  end

endmodule

// File: verilog/afe_pkg.sv
/*
 * shared widths, register map and reset values of the front end
 * configuration word union and converter code conversion
 */

package afe_pkg;

  ////////////////////////////////////////
  // converter widths
  ////////////////////////////////////////

  // channels per direction
  localparam int chan_num = 2;
  // raw ADC word, low 2 bits unused
  localparam int adc_raw_w = 16;
  localparam int smp_w = 14;
  localparam int gain_w = 16;
  // gain is fixed point with 14 fraction bits
  localparam int gain_shift = 14;

  // sample, gain and offset types
  typedef logic signed [smp_w-1:0] sample_t;
  typedef logic signed [gain_w-1:0] gain_t;
  typedef logic signed [smp_w-1:0] offset_t;

  // gain of 1.0
  localparam gain_t gain_unity = 16'sd16384;

  ////////////////////////////////////////
  // register map
  ////////////////////////////////////////

  localparam int wb_adr_w = 3;
  localparam int wb_dat_w = 32;

  localparam logic [wb_adr_w-1:0] reg_ctrl = 3'd0;
  localparam logic [wb_adr_w-1:0] reg_adc_cal0 = 3'd1;
  localparam logic [wb_adr_w-1:0] reg_adc_cal1 = 3'd2;
  localparam logic [wb_adr_w-1:0] reg_dac_cal0 = 3'd3;
  localparam logic [wb_adr_w-1:0] reg_dac_cal1 = 3'd4;

  // one bus word, seen as calibration or control register
  typedef union packed {
    struct packed {
      gain_t gain;
      logic [wb_dat_w-gain_w-smp_w-1:0] rsvd;
      offset_t offset;
    } cal;
    struct packed {
      logic [wb_dat_w-2:0] rsvd;
      logic loop_en;
    } ctrl;
  } cfg_word_u;

  // keep sign bit, invert the rest
  // converter code to two's complement and back
  function automatic logic [smp_w-1:0] code_flip(input logic [smp_w-1:0] word);
    return {word[smp_w-1], ~word[smp_w-2:0]};
  endfunction

endpackage

// File: verilog/afe_top.sv
/*
 * two-channel analog front end top level
 * register bank, ADC capture and calibration, DAC calibration and encode
 */

`timescale 1ns/1ns

module afe_top (
  input  logic                                                 adc_clk,
  input  logic                                                 top_rst,
  // ADC converter words
  input  logic [afe_pkg::chan_num-1:0][afe_pkg::adc_raw_w-1:0] adc_dat_i,
  // DAC sample streams
  input  afe_pkg::sample_t [afe_pkg::chan_num-1:0]             dac_smp_i,
  input  logic [afe_pkg::chan_num-1:0]                         dac_vld_i,
  // calibrated ADC streams
  output afe_pkg::sample_t [afe_pkg::chan_num-1:0]             adc_smp_o,
  output logic [afe_pkg::chan_num-1:0]                         adc_vld_o,
  // DAC converter codes
  output logic [afe_pkg::chan_num-1:0][afe_pkg::smp_w-1:0]     dac_code_o,
  // Wishbone slave
  input  logic                                                 wb_cyc_i,
  input  logic                                                 wb_stb_i,
  input  logic                                                 wb_we_i,
  input  logic [afe_pkg::wb_adr_w-1:0]                         wb_adr_i,
  input  logic [afe_pkg::wb_dat_w-1:0]                         wb_dat_i,
  output logic [afe_pkg::wb_dat_w-1:0]                         wb_dat_o,
  output logic                                                 wb_ack_o
);

  import afe_pkg::*;

  // configuration
  logic loop_en;
  gain_t [chan_num-1:0] adc_gain;
  gain_t [chan_num-1:0] dac_gain;
  offset_t [chan_num-1:0] adc_offset;
  offset_t [chan_num-1:0] dac_offset;

  // captured ADC streams
  sample_t [chan_num-1:0] cap_smp;
  logic [chan_num-1:0] cap_vld;
  // calibrated DAC streams, also the loopback source
  sample_t [chan_num-1:0] dac_cal_smp;
  logic [chan_num-1:0] dac_cal_vld;

  ////////////////////////////////////////
  // register bank
  ////////////////////////////////////////

  afe_cfg_regs u_cfg_regs (
    .adc_clk      (adc_clk),
    .top_rst      (top_rst),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .loop_en_o    (loop_en),
    .adc_gain_o   (adc_gain),
    .dac_gain_o   (dac_gain),
    .adc_offset_o (adc_offset),
    .dac_offset_o (dac_offset)
  );

  ////////////////////////////////////////
  // ADC path, capture then calibration
  ////////////////////////////////////////

  generate
    for (genvar i = 0; i < chan_num; i++) begin : for_adc
      adc_capture u_adc_capture (
        .adc_clk    (adc_clk),
        .top_rst    (top_rst),
        .raw_i      (adc_dat_i[i]),
        .loop_en_i  (loop_en),
        .loop_smp_i (dac_cal_smp[i]),
        .loop_vld_i (dac_cal_vld[i]),
        .smp_o      (cap_smp[i]),
        .vld_o      (cap_vld[i])
      );

      linear_calib u_adc_calib (
        .adc_clk  (adc_clk),
        .top_rst  (top_rst),
        .smp_i    (cap_smp[i]),
        .vld_i    (cap_vld[i]),
        .gain_i   (adc_gain[i]),
        .offset_i (adc_offset[i]),
        .smp_o    (adc_smp_o[i]),
        .vld_o    (adc_vld_o[i])
      );
    end
  endgenerate

  ////////////////////////////////////////
  // DAC path, calibration then encode
  ////////////////////////////////////////

  generate
    for (genvar i = 0; i < chan_num; i++) begin : for_dac
      linear_calib u_dac_calib (
        .adc_clk  (adc_clk),
        .top_rst  (top_rst),
        .smp_i    (dac_smp_i[i]),
        .vld_i    (dac_vld_i[i]),
        .gain_i   (dac_gain[i]),
        .offset_i (dac_offset[i]),
        .smp_o    (dac_cal_smp[i]),
        .vld_o    (dac_cal_vld[i])
      );

      dac_encode u_dac_encode (
        .adc_clk (adc_clk),
        .top_rst (top_rst),
        .smp_i   (dac_cal_smp[i]),
        .vld_i   (dac_cal_vld[i]),
        .code_o  (dac_code_o[i])
      );
    end
  endgenerate

endmodule

// File: verilog/dac_encode.sv
/*
 * DAC channel output register
 * two's complement to converter code, held between samples
 */

`timescale 1ns/1ns

module dac_encode (
  input  logic                       adc_clk,
  input  logic                       top_rst,
  // calibrated sample stream
  input  afe_pkg::sample_t           smp_i,
  input  logic                       vld_i,
  // converter code
  output logic [afe_pkg::smp_w-1:0]  code_o
);

  import afe_pkg::*;

  // code of sample 0, mid scale
  localparam logic [smp_w-1:0] code_zero = {1'b0, {(smp_w-1){1'b1}}};

  logic [smp_w-1:0] code_q;

  // update only on valid
  // last code stays on the pins during gaps
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      code_q <= code_zero;
    end else if (vld_i) begin
      code_q <= code_flip(smp_i);
    end
  end

  assign code_o = code_q;

endmodule

// File: verilog/linear_calib.sv
/*
 * gain/offset calibration of one sample stream
 * two stages, multiply then shift, offset add and saturation
 */

`timescale 1ns/1ns

module linear_calib (
  input  logic               adc_clk,
  input  logic               top_rst,
  // input stream
  input  afe_pkg::sample_t   smp_i,
  input  logic               vld_i,
  // calibration
  input  afe_pkg::gain_t     gain_i,
  input  afe_pkg::offset_t   offset_i,
  // output stream
  output afe_pkg::sample_t   smp_o,
  output logic               vld_o
);

  import afe_pkg::*;

  // full signed product
  logic signed [smp_w+gain_w-1:0] prod_q;
  logic vld1_q;
  // scaled product plus offset, one guard bit
  logic signed [smp_w+gain_w-1:0] prod_shr;
  logic signed [smp_w+gain_w:0] sum;
  // saturation flags
  logic sat_hi;
  logic sat_lo;
  sample_t sat_smp;
  sample_t smp_q;
  logic vld2_q;

  ////////////////////////////////////////
  // stage 1, multiply
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    prod_q <= smp_i * gain_i;
  end

  ////////////////////////////////////////
  // stage 2, shift, add, saturate
  ////////////////////////////////////////

  assign prod_shr = prod_q >>> gain_shift;
  assign sum = prod_shr + offset_i;

  // fits in smp_w bits when all bits above the sample sign match
  assign sat_hi = ~sum[smp_w+gain_w] & (|sum[smp_w+gain_w-1:smp_w-1]);
  assign sat_lo = sum[smp_w+gain_w] & ~(&sum[smp_w+gain_w-1:smp_w-1]);

  always_comb begin
    if (sat_hi) begin
      // +8191
      sat_smp = {1'b0, {(smp_w-1){1'b1}}};
    end else if (sat_lo) begin
      // -8192
      sat_smp = {1'b1, {(smp_w-1){1'b0}}};
    end else begin
      sat_smp = sum[smp_w-1:0];
    end
  end

  always_ff @(posedge adc_clk) begin
    smp_q <= sat_smp;
  end

  // valid follows the data through both stages
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      vld1_q <= 1'b0;
      vld2_q <= 1'b0;
    end else begin
      vld1_q <= vld_i;
      vld2_q <= vld1_q;
    end
  end

  assign smp_o = smp_q;
  assign vld_o = vld2_q;

endmodule
